// File: coreIsaPkg.sv
// coreIsaPkg: RV32I integer subset encodings, field positions and widths
package coreIsaPkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////
  localparam int xlen        = 32;               // data path width
  localparam int ilen        = 32;               // instruction width
  localparam int regAddrBits = 5;                // x0..x31
  localparam int numRegs     = 1 << regAddrBits;
  localparam int opcodeBits  = 7;
  localparam int shamtBits   = 5;                // shift amount, low bits of operand b

  // field lsb positions inside the instruction word
  localparam int rdLsb  = 7;
  localparam int f3Lsb  = 12;
  localparam int rs1Lsb = 15;
  localparam int rs2Lsb = 20;
  localparam int f7Lsb  = 25;

  ////////////////////////////////////////////////////////////
  // major opcodes, only the three this core runs
  ////////////////////////////////////////////////////////////
  typedef enum logic [opcodeBits-1:0] {
    opOp    = 7'b0110011,   // reg-reg alu
    opOpImm = 7'b0010011,   // reg-imm alu
    opLui   = 7'b0110111
  } opcodeT;

  // alu operations seen by execute
  typedef enum logic [3:0] {
    aluAdd   = 4'd0,
    aluSub   = 4'd1,
    aluSll   = 4'd2,
    aluSlt   = 4'd3,
    aluSltu  = 4'd4,
    aluXor   = 4'd5,
    aluSrl   = 4'd6,
    aluSra   = 4'd7,
    aluOr    = 4'd8,
    aluAnd   = 4'd9,
    aluPassB = 4'd10        // lui, result is the u-immediate
  } aluOpT;

  // funct3 codes for OP / OP-IMM
  localparam logic [2:0] f3AddSub = 3'b000;
  localparam logic [2:0] f3Sll    = 3'b001;
  localparam logic [2:0] f3Slt    = 3'b010;
  localparam logic [2:0] f3Sltu   = 3'b011;
  localparam logic [2:0] f3Xor    = 3'b100;
  localparam logic [2:0] f3SrlSra = 3'b101;
  localparam logic [2:0] f3Or     = 3'b110;
  localparam logic [2:0] f3And    = 3'b111;

  // funct7 codes
  localparam logic [6:0] f7Base = 7'b0000000;
  localparam logic [6:0] f7Alt  = 7'b0100000;  // sub / sra

endpackage

// File: corePipePkg.sv
// corePipePkg: packed bundles passed between the pipeline stages
package corePipePkg;

  import coreIsaPkg::*;

  ////////////////////////////////////////////////////////////
  // decode -> execute
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic                   valid;     // slot holds an instruction
    logic                   illegal;   // unsupported encoding
    aluOpT                  aluOp;
    logic                   useImm;    // operand b from imm
    logic [regAddrBits-1:0] rs1;
    logic [regAddrBits-1:0] rs2;
    logic [regAddrBits-1:0] rd;
    logic                   regWrite;  // low for x0 and illegal
    logic [xlen-1:0]        rs1Val;    // as read in decode
    logic [xlen-1:0]        rs2Val;
    logic [xlen-1:0]        imm;       // i- or u-type, already extended
  } decExT;

  ////////////////////////////////////////////////////////////
  // execute -> result, also the forwarding source
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic                   valid;
    logic                   illegal;
    logic [regAddrBits-1:0] rd;
    logic                   regWrite;
    logic [xlen-1:0]        data;      // alu result
  } exResT;

  ////////////////////////////////////////////////////////////
  // register file write port
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic                   en;
    logic [regAddrBits-1:0] addr;
    logic [xlen-1:0]        data;
  } regWriteT;

endpackage

// File: decodeStage.sv
// decodeStage: splits the instruction, reads operands, registers the decode bundle
module decodeStage import coreIsaPkg::*, corePipePkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   instrValid,
  input  logic [ilen-1:0]        instr,
  output logic [regAddrBits-1:0] rdAddrA,
  output logic [regAddrBits-1:0] rdAddrB,
  input  logic [xlen-1:0]        rdDataA,
  input  logic [xlen-1:0]        rdDataB,
  output decExT                  decEx
);

  logic [opcodeBits-1:0]  opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  logic [regAddrBits-1:0] rd;
  logic [xlen-1:0]        iImm;
  logic [xlen-1:0]        uImm;
  logic                   legal;
  aluOpT                  aluOp;
  logic                   useImm;
  logic [xlen-1:0]        imm;
  decExT                  decNext;

  // funct3 -> op for the f7Base forms, shared by OP and OP-IMM
  function automatic aluOpT baseOp(input logic [2:0] f3);
    aluOpT op;
    case (f3)
      f3AddSub: op = aluAdd;
      f3Sll:    op = aluSll;
      f3Slt:    op = aluSlt;
      f3Sltu:   op = aluSltu;
      f3Xor:    op = aluXor;
      f3SrlSra: op = aluSrl;
      f3Or:     op = aluOr;
      default:  op = aluAnd;   // f3And
    endcase
    return op;
  endfunction

  ////////////////////////////////////////////////////////////
  // field split
  ////////////////////////////////////////////////////////////
  assign opcode  = instr[opcodeBits-1:0];
  assign funct3  = instr[f3Lsb +: 3];
  assign funct7  = instr[f7Lsb +: 7];
  assign rd      = instr[rdLsb +: regAddrBits];
  assign rdAddrA = instr[rs1Lsb +: regAddrBits];   // rs1
  assign rdAddrB = instr[rs2Lsb +: regAddrBits];   // rs2, junk for imm forms

  assign iImm = {{(xlen-12){instr[ilen-1]}}, instr[ilen-1:20]};   // sign extended
  assign uImm = {instr[ilen-1:12], 12'b0};

  ////////////////////////////////////////////////////////////
  // opcode / funct decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    legal  = 1'b0;
    aluOp  = baseOp(funct3);
    useImm = 1'b0;
    imm    = iImm;
    case (opcode)
      opOp: begin
        if (funct7 == f7Base) begin
          legal = 1'b1;                      // all eight funct3 valid
        end else if (funct7 == f7Alt) begin
          if (funct3 == f3AddSub) begin
            aluOp = aluSub;
            legal = 1'b1;
          end else if (funct3 == f3SrlSra) begin
            aluOp = aluSra;
            legal = 1'b1;
          end
        end
      end
      opOpImm: begin
        useImm = 1'b1;
        if (funct3 == f3Sll) begin
          legal = (funct7 == f7Base);        // slli
        end else if (funct3 == f3SrlSra) begin
          if (funct7 == f7Alt) begin
            aluOp = aluSra;                  // srai
          end
          legal = (funct7 == f7Base) || (funct7 == f7Alt);
        end else begin
          legal = 1'b1;                      // addi slti sltiu xori ori andi
        end
      end
      opLui: begin
        aluOp  = aluPassB;
        useImm = 1'b1;
        imm    = uImm;
        legal  = 1'b1;
      end
      default: legal = 1'b0;                 // anything else traps as illegal
    endcase
  end

  // next bundle; instrValid low gives a bubble
  always_comb begin
    decNext.valid    = instrValid;
    decNext.illegal  = instrValid && !legal;
    decNext.aluOp    = aluOp;
    decNext.useImm   = useImm;
    decNext.rs1      = rdAddrA;
    decNext.rs2      = rdAddrB;
    decNext.rd       = rd;
    decNext.regWrite = instrValid && legal && (rd != '0);
    decNext.rs1Val   = rdDataA;
    decNext.rs2Val   = rdDataB;
    decNext.imm      = imm;
  end

  // only the control bits are reset
  always_ff @(posedge clk) begin
    if (rst) begin
      decEx.valid    <= 1'b0;
      decEx.illegal  <= 1'b0;
      decEx.regWrite <= 1'b0;
    end else begin
      decEx <= decNext;
    end
  end

endmodule

// File: executeStage.sv
// executeStage: operand forwarding and ALU, registers the result bundle
module executeStage import coreIsaPkg::*, corePipePkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  decExT decEx,
  output exResT exRes
);

  logic                 fwdA;
  logic                 fwdB;
  logic [xlen-1:0]      opA;
  logic [xlen-1:0]      rs2Fwd;
  logic [xlen-1:0]      opB;
  logic [shamtBits-1:0] shamt;
  logic [xlen-1:0]      aluRes;
  exResT                exNext;

  ////////////////////////////////////////////////////////////
  // forwarding from the previous instruction
  ////////////////////////////////////////////////////////////
  // older than that comes through the regfile bypass
  assign fwdA = exRes.valid && exRes.regWrite && (decEx.rs1 != '0) &&
                (exRes.rd == decEx.rs1);
  assign fwdB = exRes.valid && exRes.regWrite && (decEx.rs2 != '0) &&
                (exRes.rd == decEx.rs2);

  assign opA    = fwdA ? exRes.data : decEx.rs1Val;
  assign rs2Fwd = fwdB ? exRes.data : decEx.rs2Val;
  assign opB    = decEx.useImm ? decEx.imm : rs2Fwd;   // imm forms ignore rs2
  assign shamt  = opB[shamtBits-1:0];                  // srai upper imm bits dropped here

  ////////////////////////////////////////////////////////////
  // alu
  ////////////////////////////////////////////////////////////
  always_comb begin
    aluRes = '0;
    case (decEx.aluOp)
      aluAdd:   aluRes = opA + opB;
      aluSub:   aluRes = opA - opB;
      aluSll:   aluRes = opA << shamt;
      aluSlt:   aluRes = {{(xlen-1){1'b0}}, ($signed(opA) < $signed(opB))};
      aluSltu:  aluRes = {{(xlen-1){1'b0}}, (opA < opB)};
      aluXor:   aluRes = opA ^ opB;
      aluSrl:   aluRes = opA >> shamt;
      aluSra:   aluRes = $signed(opA) >>> shamt;   // sign fill
      aluOr:    aluRes = opA | opB;
      aluAnd:   aluRes = opA & opB;
      aluPassB: aluRes = opB;                       // lui
      default:  aluRes = '0;
    endcase
  end

  always_comb begin
    exNext.valid    = decEx.valid;
    exNext.illegal  = decEx.illegal;
    exNext.rd       = decEx.rd;
    exNext.regWrite = decEx.regWrite;
    exNext.data     = aluRes;
  end

  // result register, data left unreset
  always_ff @(posedge clk) begin
    if (rst) begin
      exRes.valid    <= 1'b0;
      exRes.illegal  <= 1'b0;
      exRes.regWrite <= 1'b0;
    end else begin
      exRes <= exNext;
    end
  end

endmodule

// File: flist.f
coreIsaPkg.sv
corePipePkg.sv
regFile.sv
decodeStage.sv
executeStage.sv
resultStage.sv
intCore.sv
tbIntCore.sv

// File: intCore.sv
// intCore: three-stage RV32I integer core, decode / execute / result around the regfile
module intCore import coreIsaPkg::*, corePipePkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   instrValid,
  input  logic [ilen-1:0]        instr,
  output logic                   retireValid,
  output logic                   retireIllegal,
  output logic [regAddrBits-1:0] retireRd,
  output logic [xlen-1:0]        retireData
);

  logic [regAddrBits-1:0] rdAddrA;
  logic [regAddrBits-1:0] rdAddrB;
  logic [xlen-1:0]        rdDataA;
  logic [xlen-1:0]        rdDataB;
  decExT                  decEx;    // decode -> execute
  exResT                  exRes;    // execute -> result, fed back for forwarding
  regWriteT               rfWrite;  // result -> regfile

  decodeStage u_decode (
    .clk, .rst,
    .instrValid, .instr,
    .rdAddrA, .rdAddrB, .rdDataA, .rdDataB,
    .decEx
  );

  executeStage u_execute (
    .clk, .rst,
    .decEx, .exRes
  );

  resultStage u_result (
    .exRes, .rfWrite,
    .retireValid, .retireIllegal, .retireRd, .retireData
  );

  regFile u_regFile (
    .clk, .rst,
    .rdAddrA, .rdAddrB, .rdDataA, .rdDataB,
    .wr(rfWrite)
  );

endmodule

// File: regFile.sv
// regFile: 32 x 32 integer register file, two reads, one write, write-through
module regFile import coreIsaPkg::*, corePipePkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [regAddrBits-1:0] rdAddrA,
  input  logic [regAddrBits-1:0] rdAddrB,
  output logic [xlen-1:0]        rdDataA,
  output logic [xlen-1:0]        rdDataB,
  input  regWriteT               wr
);

  logic [xlen-1:0] regs [numRegs];

  // one read port; x0 first, then bypass of the write in flight
  function automatic logic [xlen-1:0] readPort(input logic [regAddrBits-1:0] addr);
    logic [xlen-1:0] val;
    if (addr == '0) begin
      val = '0;                         // x0 hardwired
    end else if (wr.en && (wr.addr == addr)) begin
      val = wr.data;                    // same-cycle write wins
    end else begin
      val = regs[addr];
    end
    return val;
  endfunction

  // write, x0 never stored
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.en && (wr.addr != '0)) begin
      regs[wr.addr] <= wr.data;
    end
  end

  always_comb begin
    rdDataA = readPort(rdAddrA);
    rdDataB = readPort(rdAddrB);
  end

endmodule

// File: resultStage.sv
// resultStage: turns the result bundle into the regfile write and the retire strobe
module resultStage import coreIsaPkg::*, corePipePkg::*; (
  input  exResT                  exRes,
  output regWriteT               rfWrite,
  output logic                   retireValid,
  output logic                   retireIllegal,
  output logic [regAddrBits-1:0] retireRd,
  output logic [xlen-1:0]        retireData
);

  logic doWrite;

  ////////////////////////////////////////////////////////////
  // register file write
  ////////////////////////////////////////////////////////////
  // regWrite already low for x0 and illegal
  assign doWrite = exRes.valid && exRes.regWrite;

  always_comb begin
    rfWrite.en   = doWrite;
    rfWrite.addr = exRes.rd;
    rfWrite.data = exRes.data;
  end

  ////////////////////////////////////////////////////////////
  // retire port
  ////////////////////////////////////////////////////////////
  assign retireValid   = exRes.valid;                   // one pulse per instruction
  assign retireIllegal = exRes.valid && exRes.illegal;
  assign retireRd      = exRes.rd;

  // illegal retires with zero data
  assign retireData = exRes.illegal ? '0 : exRes.data;

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the integer core testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module tbIntCore -o simIntCore

./obj_dir/simIntCore | tee sim.log

if grep -q "Finished with errors" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi

echo "simulation passed"
exit 0

// File: tbIntCore.sv
// tbIntCore: directed testbench for the integer core, checks retires against a register model
module tbIntCore import coreIsaPkg::*, corePipePkg::*;;

  localparam int clkHalf = 4;
  // tests take about 540 cycles, limit at roughly four times that
  localparam int maxCycles = 2000;

  // one expected retire, pushed in issue order
  typedef struct packed {
    logic [regAddrBits-1:0] rd;
    logic [xlen-1:0]        data;
    logic                   illegal;
    int                     issueCycle;
  } retireExpT;

  logic                   clk;
  logic                   rst;
  logic                   instrValid;
  logic [ilen-1:0]        instr;
  logic                   retireValid;
  logic                   retireIllegal;
  logic [regAddrBits-1:0] retireRd;
  logic [xlen-1:0]        retireData;

  logic [xlen-1:0] model [numRegs];   // architectural state in issue order
  retireExpT       expQ [$];
  int              cycleCount;
  int              errCount;
  int              testsPassed;
  int              testsFailed;
  integer          seed;

  intCore i_dut (
    .clk, .rst, .instrValid, .instr,
    .retireValid, .retireIllegal, .retireRd, .retireData
  );

  initial clk = 1'b0;
  always #clkHalf clk = ~clk;

  ////////////////////////////////////////////////////////////
  // encoders and reference model
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opOp};
  endfunction

  function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, opOpImm};
  endfunction

  function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, opLui};
  endfunction

  // funct3 rules; alt picks sub / sra
  function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;  // signed via bias
      3'd3: r = (a < b) ? 32'd1 : 32'd0;
      3'd4: r = a ^ b;
      3'd5: begin
        r = a >> b[4:0];
        if (alt && a[31]) begin
          r = r | ~(32'hffff_ffff >> b[4:0]);   // sign fill
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic [31:0] refResult(input logic [31:0] ins, output logic ill);
    logic [6:0]  op;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] r;
    op  = ins[6:0];
    f3  = ins[14:12];
    f7  = ins[31:25];
    a   = model[ins[19:15]];
    ill = 1'b0;
    r   = '0;
    if (op == opLui) begin
      r = {ins[31:12], 12'h000};
    end else if (op == opOp) begin
      if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
        r = refAlu(f3, f7[5], a, model[ins[24:20]]);
      end else begin
        ill = 1'b1;
      end
    end else if (op == opOpImm) begin
      if ((f3 == 3'd1 && f7 != 7'h00) || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20)) begin
        ill = 1'b1;                                   // bad shift-imm funct7
      end else begin
        r = refAlu(f3, (f3 == 3'd5) && f7[5], a, {{20{ins[31]}}, ins[31:20]});
      end
    end else begin
      ill = 1'b1;
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // drive helpers, all entered 1 unit after a rising edge
  ////////////////////////////////////////////////////////////
  task automatic issue(input logic [31:0] ins);
    retireExpT e;
    e.data    = refResult(ins, e.illegal);
    e.rd      = ins[11:7];
    e.issueCycle = cycleCount;
    if (!e.illegal && e.rd != 5'd0) begin
      model[e.rd] = e.data;
    end
    expQ.push_back(e);
    instrValid = 1'b1;
    instr      = ins;
    @(posedge clk);
    #1;
    instrValid = 1'b0;
  endtask

  task automatic idleCycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic drainPipe();
    do begin
      @(posedge clk);
    end while (expQ.size() != 0);
    #1;
  endtask

  // lui + addi, upper part corrected for the sign of the low 12 bits
  task automatic loadReg(input logic [4:0] rd, input logic [31:0] v);
    issue(uType(v[31:12] + 20'(v[11]), rd));
    issue(iType(v[11:0], rd, f3AddSub, rd));
  endtask

  task automatic issueFillers(input int n);
    for (int i = 0; i < n; i++) begin
      issue(iType(12'(i + 1), 5'd0, f3Or, 5'(20 + i)));   // unrelated regs
    end
  endtask

  task automatic reportTest(input string name, input int startErr);
    if (errCount == startErr) begin
      testsPassed++;
      $display("test %s passed", name);
    end else begin
      testsFailed++;
      $display("test %s failed with %0d errors", name, errCount - startErr);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // retire checker, sampled mid-cycle
  ////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    if (!rst && retireValid) begin
      if (expQ.size() == 0) begin
        $display("retire seen with no instruction in flight at cycle %0d", cycleCount);
        errCount++;
      end else begin
        if (retireRd !== expQ[0].rd) begin
          $display("Fail retireRd: got %h expected %h", retireRd, expQ[0].rd);
          errCount++;
        end
        if (retireData !== expQ[0].data) begin
          $display("Fail retireData: got %h expected %h", retireData, expQ[0].data);
          errCount++;
        end
        if (retireIllegal !== expQ[0].illegal) begin
          $display("Fail retireIllegal: got %h expected %h", retireIllegal, expQ[0].illegal);
          errCount++;
        end
        if (cycleCount != expQ[0].issueCycle + 2) begin
          $display("instruction issued at cycle %0d retired at cycle %0d, not two cycles later",
                   expQ[0].issueCycle, cycleCount);
          errCount++;
        end
        void'(expQ.pop_front());
      end
    end
  end

  // run limit
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount == maxCycles) begin
      $display("timeout, run stopped after %0d cycles", maxCycles);
      $display("Finished with errors");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////
  task automatic addiAfterReset();
    int          startErr;
    logic [11:0] imm;
    startErr = errCount;
    idleCycles(6);                    // nothing may retire here
    for (int r = 1; r < 32; r++) begin
      imm = 12'($random(seed));
      issue(iType(imm, 5'd0, f3AddSub, 5'(r)));
      idleCycles(2);
    end
    drainPipe();
    reportTest("addi after reset", startErr);
  endtask

  task automatic regRegOps();
    int         startErr;
    logic [2:0] f3;
    logic [6:0] f7;
    startErr = errCount;
    for (int i = 1; i < 8; i++) begin
      loadReg(5'(i), $random(seed));
    end
    loadReg(5'd8, 32'h8000_0001);     // negative operand for slt vs sltu
    for (int op = 0; op < 10; op++) begin
      f3 = (op < 8) ? 3'(op) : ((op == 8) ? f3AddSub : f3SrlSra);
      f7 = (op < 8) ? f7Base : f7Alt;   // 8 sub, 9 sra
      for (int k = 0; k < 4; k++) begin
        issue(rType(f7, 5'(1 + {$random(seed)} % 8), 5'(1 + {$random(seed)} % 8), f3,
                    5'(9 + {$random(seed)} % 23)));
      end
    end
    drainPipe();
    reportTest("register-register ops", startErr);
  endtask

  task automatic dependencyChains();
    int startErr;
    startErr = errCount;
    for (int d = 1; d <= 3; d++) begin
      loadReg(5'd1, $random(seed));
      loadReg(5'd2, $random(seed));
      drainPipe();
      issue(rType(f7Base, 5'd2, 5'd1, f3AddSub, 5'd3));   // x3 = x1 + x2
      issueFillers(d - 1);
      issue(rType(f7Alt, 5'd1, 5'd3, f3AddSub, 5'd4));    // rs1 needs x3
      issueFillers(d - 1);
      issue(rType(f7Base, 5'd4, 5'd2, f3Xor, 5'd5));      // rs2 needs x4
      issueFillers(d - 1);
      issue(rType(f7Base, 5'd5, 5'd5, f3And, 5'd6));      // both need x5
      drainPipe();
    end
    reportTest("dependency chains", startErr);
  endtask

  task automatic luiAndShifts();
    int startErr;
    startErr = errCount;
    issue(uType(20'hfffff, 5'd7));
    issue(uType(20'($random(seed)), 5'd8));
    loadReg(5'd1, 32'h8000_00f1);
    for (int s = 0; s <= 31; s += 31) begin
      issue(iType({f7Base, 5'(s)}, 5'd1, f3Sll, 5'd10));
      issue(iType({f7Base, 5'(s)}, 5'd1, f3SrlSra, 5'd11));
      issue(iType({f7Alt, 5'(s)}, 5'd1, f3SrlSra, 5'd12));  // srai
    end
    drainPipe();
    reportTest("lui and shifts", startErr);
  endtask

  task automatic zeroAndIllegal();
    int startErr;
    startErr = errCount;
    loadReg(5'd1, $random(seed));
    loadReg(5'd9, 32'h1234_5678);
    issue(iType(12'h005, 5'd1, f3AddSub, 5'd0));          // addi to x0
    issue(rType(f7Base, 5'd1, 5'd1, f3Or, 5'd0));
    issue(rType(f7Base, 5'd0, 5'd0, f3AddSub, 5'd13));    // x0 must still read 0
    issue(rType(7'h01, 5'd1, 5'd1, f3AddSub, 5'd9));      // mul encoding
    issue({12'h000, 5'd1, 3'b010, 5'd9, 7'b0000011});     // load opcode
    issue(iType({f7Alt, 5'd3}, 5'd1, f3Sll, 5'd9));
    issue(rType(f7Alt, 5'd1, 5'd1, f3Xor, 5'd9));
    issue(iType(12'h000, 5'd9, f3AddSub, 5'd14));         // x9 unchanged
    drainPipe();
    reportTest("x0 and illegal", startErr);
  endtask

  task automatic randomStream();
    int          startErr;
    int          kind;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    startErr = errCount;
    for (int n = 0; n < 200; n++) begin
      kind = {$random(seed)} % 3;
      f3   = 3'($random(seed));
      f7   = ((f3 == f3AddSub || f3 == f3SrlSra) && $random(seed) % 2 != 0) ? f7Alt : f7Base;
      imm  = 12'($random(seed));
      if (f3 == f3Sll || f3 == f3SrlSra) begin
        imm = {f7, imm[4:0]};           // legal shift-imm form
      end
      if (kind == 0) begin
        issue(rType(f7, 5'($random(seed)), 5'($random(seed)), f3, 5'($random(seed))));
      end else if (kind == 1) begin
        issue(iType(imm, 5'($random(seed)), f3, 5'($random(seed))));
      end else begin
        issue(uType(20'($random(seed)), 5'($random(seed))));
      end
      if ({$random(seed)} % 4 == 0) begin
        idleCycles(1 + {$random(seed)} % 2);
      end
    end
    drainPipe();
    reportTest("random stream", startErr);
  endtask

  initial begin
    seed        = 30;
    cycleCount  = 0;
    errCount    = 0;
    testsPassed = 0;
    testsFailed = 0;
    rst         = 1'b1;
    instrValid  = 1'b0;
    instr       = '0;
    for (int i = 0; i < numRegs; i++) begin
      model[i] = '0;
    end
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    addiAfterReset();
    regRegOps();
    dependencyChains();
    luiAndShifts();
    zeroAndIllegal();
    randomStream();
    $display("tests passed %0d, tests failed %0d, check errors %0d",
             testsPassed, testsFailed, errCount);
    if (errCount == 0 && testsFailed == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
